//--- branch_pkg.sv
package branch_pkg;

  localparam int slot_count = 8;
  localparam int slot_idx_w = 3;
  localparam int count_w    = 4;
  localparam int data_w     = 32;
  localparam int offset_w   = 16;

  // instruction class, nop must stay zero
  typedef enum logic [2:0] {
    op_nop   = 3'd0,
    op_alu   = 3'd1,
    op_load  = 3'd2,
    op_store = 3'd3,
    op_bjp   = 3'd4
  } opcode_t;

  // lt and ge compare as signed
  typedef enum logic [1:0] {
    cond_eq = 2'd0,
    cond_ne = 2'd1,
    cond_lt = 2'd2,
    cond_ge = 2'd3
  } cond_t;

  typedef struct packed {
    opcode_t               opcode;
    cond_t                 cond;
    logic [data_w-1:0]     pc;
    logic [offset_w-1:0]   offset;
    logic [data_w-1:0]     operand_l;
    logic [data_w-1:0]     operand_r;
  } inst_t;

  typedef inst_t [slot_count-1:0] packet_t;

  typedef struct packed {
    packet_t               packet;
    logic [slot_count-1:0] branch_mask;
    logic [count_w-1:0]    branch_count;
  } decoded_t;

  typedef struct packed {
    packet_t               packet;
    logic [slot_count-1:0] taken_mask;
    logic                  has_taken;
    logic [slot_idx_w-1:0] taken_idx;
    logic [count_w-1:0]    resolved_count;
  } resolved_t;

  typedef struct packed {
    packet_t               packet;
    logic [count_w-1:0]    resolved_count;
  } issue_t;

  typedef struct packed {
    logic [data_w-1:0]     target_pc;
  } redirect_t;

  // lowest set bit by halving the mask, all ones when empty
  function automatic logic [slot_idx_w-1:0] first_set_index(
    input logic [slot_count-1:0] mask
  );
    logic [slot_idx_w-1:0] idx;
    logic [3:0]            half;
    logic [1:0]            quarter;
    idx[2]  = ~(|mask[3:0]);
    half    = idx[2] ? mask[7:4] : mask[3:0];
    idx[1]  = ~(|half[1:0]);
    quarter = idx[1] ? half[3:2] : half[1:0];
    idx[0]  = ~quarter[0];
    return idx;
  endfunction

endpackage

//--- branch_decode.sv
`timescale 1ns/1ns

module branch_decode (
  input  logic                 w_IssueFifoFire_1,
  input  logic                 rstn,
  input  logic                 i_pkt_valid,
  input  branch_pkg::packet_t  i_pkt,
  output logic                 o_dec_valid,
  output branch_pkg::decoded_t o_dec
);

  logic [branch_pkg::slot_count-1:0] branch_mask;
  logic [branch_pkg::count_w-1:0]    branch_count;

  // mark bjp slots and count them
  always_comb begin
    branch_count = '0;
    for (int i = 0; i < branch_pkg::slot_count; i++) begin
      branch_mask[i] = (i_pkt[i].opcode == branch_pkg::op_bjp);
      branch_count   = branch_count +
                       {{(branch_pkg::count_w-1){1'b0}}, branch_mask[i]};
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= i_pkt_valid;
    end
  end

  // payload only moves on a strobe
  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_dec <= '0;
    end else if (i_pkt_valid) begin
      o_dec.packet       <= i_pkt;
      o_dec.branch_mask  <= branch_mask;
      o_dec.branch_count <= branch_count;
    end
  end

endmodule

//--- branch_execute.sv
`timescale 1ns/1ns

module branch_execute (
  input  logic                  w_IssueFifoFire_1,
  input  logic                  rstn,
  input  logic                  i_dec_valid,
  input  branch_pkg::decoded_t  i_dec,
  output logic                  o_exe_valid,
  output branch_pkg::resolved_t o_exe
);

  logic [branch_pkg::slot_count-1:0] cond_hit;
  logic [branch_pkg::slot_count-1:0] taken_mask;
  logic                              has_taken;
  logic [branch_pkg::slot_idx_w-1:0] taken_idx;
  logic [branch_pkg::count_w-1:0]    resolved_count;

  // one comparator per slot, all in parallel
  always_comb begin
    for (int i = 0; i < branch_pkg::slot_count; i++) begin
      case (i_dec.packet[i].cond)
        branch_pkg::cond_eq:
          cond_hit[i] = (i_dec.packet[i].operand_l == i_dec.packet[i].operand_r);
        branch_pkg::cond_ne:
          cond_hit[i] = (i_dec.packet[i].operand_l != i_dec.packet[i].operand_r);
        branch_pkg::cond_lt:
          cond_hit[i] = (signed'(i_dec.packet[i].operand_l) <
                         signed'(i_dec.packet[i].operand_r));
        default:
          cond_hit[i] = (signed'(i_dec.packet[i].operand_l) >=
                         signed'(i_dec.packet[i].operand_r));
      endcase
    end
  end

  assign taken_mask = cond_hit & i_dec.branch_mask;
  assign has_taken  = |taken_mask;
  assign taken_idx  = branch_pkg::first_set_index(taken_mask);

  // branches up to the taken one, or all of them when none is taken
  always_comb begin
    resolved_count = i_dec.branch_count;
    if (has_taken) begin
      resolved_count = '0;
      for (int i = 0; i < branch_pkg::slot_count; i++) begin
        if (i <= int'(taken_idx)) begin
          resolved_count = resolved_count +
                           {{(branch_pkg::count_w-1){1'b0}}, i_dec.branch_mask[i]};
        end
      end
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_exe_valid <= 1'b0;
    end else begin
      o_exe_valid <= i_dec_valid;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_exe <= '0;
    end else if (i_dec_valid) begin
      o_exe.packet         <= i_dec.packet;
      o_exe.taken_mask     <= taken_mask;
      o_exe.has_taken      <= has_taken;
      o_exe.taken_idx      <= taken_idx;
      o_exe.resolved_count <= resolved_count;
    end
  end

endmodule

//--- branch_result.sv
`timescale 1ns/1ns

module branch_result (
  input  logic                  w_IssueFifoFire_1,
  input  logic                  rstn,
  input  logic                  i_exe_valid,
  input  branch_pkg::resolved_t i_exe,
  output logic                  o_issue_valid,
  output branch_pkg::issue_t    o_issue,
  output logic                  o_redirect_valid,
  output branch_pkg::redirect_t o_redirect
);

  branch_pkg::packet_t               issue_pkt;
  logic [branch_pkg::slot_idx_w-1:0] redirect_idx;
  branch_pkg::inst_t                 taken_inst;
  logic [branch_pkg::data_w-1:0]     target_pc;

  // squash everything younger than the taken branch
  always_comb begin
    for (int i = 0; i < branch_pkg::slot_count; i++) begin
      if (i_exe.has_taken && (i > int'(i_exe.taken_idx))) begin
        issue_pkt[i] = '0;
      end else begin
        issue_pkt[i] = i_exe.packet[i];
      end
    end
  end

  // redirect slot picked straight from the taken mask
  assign redirect_idx = branch_pkg::first_set_index(i_exe.taken_mask);
  assign taken_inst   = i_exe.packet[redirect_idx];
  assign target_pc    = taken_inst.pc +
                        {{(branch_pkg::data_w-branch_pkg::offset_w)
                          {taken_inst.offset[branch_pkg::offset_w-1]}},
                         taken_inst.offset};

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_issue_valid    <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else begin
      o_issue_valid    <= i_exe_valid;
      o_redirect_valid <= i_exe_valid && i_exe.has_taken;
    end
  end

  always_ff @(posedge w_IssueFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_issue    <= '0;
      o_redirect <= '0;
    end else if (i_exe_valid) begin
      o_issue.packet         <= issue_pkt;
      o_issue.resolved_count <= i_exe.resolved_count;
      // target only matters when a branch was taken
      if (i_exe.has_taken) begin
        o_redirect.target_pc <= target_pc;
      end
    end
  end

endmodule

//--- branch_detect_top.sv
`timescale 1ns/1ns

module branch_detect_top (
  input  logic                  w_IssueFifoFire_1,
  input  logic                  rstn,
  input  logic                  i_pkt_valid,
  input  branch_pkg::packet_t   i_pkt,
  output logic                  o_issue_valid,
  output branch_pkg::issue_t    o_issue,
  output logic                  o_redirect_valid,
  output branch_pkg::redirect_t o_redirect
);

  logic                  dec_valid;
  branch_pkg::decoded_t  dec;
  logic                  exe_valid;
  branch_pkg::resolved_t exe;

  branch_decode u_decode (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_pkt_valid       (i_pkt_valid),
    .i_pkt             (i_pkt),
    .o_dec_valid       (dec_valid),
    .o_dec             (dec)
  );

  branch_execute u_execute (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_dec_valid       (dec_valid),
    .i_dec             (dec),
    .o_exe_valid       (exe_valid),
    .o_exe             (exe)
  );

  branch_result u_result (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_exe_valid       (exe_valid),
    .i_exe             (exe),
    .o_issue_valid     (o_issue_valid),
    .o_issue           (o_issue),
    .o_redirect_valid  (o_redirect_valid),
    .o_redirect        (o_redirect)
  );

endmodule

//--- branch_detect_properties.sv
`timescale 1ns/1ns

module branch_detect_properties (
  input logic w_IssueFifoFire_1,
  input logic rstn,
  input logic i_pkt_valid,
  input logic i_issue_valid,
  input logic i_redirect_valid
);

  // redirect only ever rides along with an issue packet
  a_redirect_with_issue: assert property (
    @(posedge w_IssueFifoFire_1) disable iff (!rstn)
      i_redirect_valid |-> i_issue_valid
  ) else $error("redirect valid without issue valid");

  a_issue_latency: assert property (
    @(posedge w_IssueFifoFire_1) disable iff (!rstn)
      i_pkt_valid |-> ##3 i_issue_valid
  ) else $error("issue valid missing three cycles after packet valid");

  a_issue_origin: assert property (
    @(posedge w_IssueFifoFire_1) disable iff (!rstn)
      i_issue_valid |-> $past(i_pkt_valid, 3)
  ) else $error("issue valid without a packet three cycles earlier");

  a_quiet_in_reset: assert property (
    @(posedge w_IssueFifoFire_1)
      !rstn |-> (!i_issue_valid && !i_redirect_valid)
  ) else $error("valid output high during reset");

endmodule

//--- tb_branch_detect.sv
`timescale 1ns/1ns

module tb_branch_detect;

  localparam int clk_period  = 40;
  localparam int row_count   = 8;
  localparam int drain_limit = 20;

  // slot 0 sits in the lowest field of each column
  // kinds nibble: 0..3 nop/alu/load/store, 8 + cond for a branch
  // rels per slot: 0 equal, 1 left less, 2 left greater
  // exp_idx of 8 means nothing taken
  typedef struct packed {
    logic [31:0] kinds;
    logic [15:0] rels;
    logic [3:0]  exp_idx;
    logic [3:0]  exp_count;
  } row_t;

  localparam logic [55:0] stim_table [row_count] = '{
    {32'h3210_1230, 16'b00_00_00_00_00_00_00_00, 4'd8, 4'd0},
    {32'h1BA3_9281, 16'b00_01_10_00_00_00_01_00, 4'd8, 4'd4},
    {32'h3123_1821, 16'b00_00_00_00_00_00_00_00, 4'd2, 4'd1},
    {32'h12A1_32B1, 16'b00_00_01_00_00_00_01_00, 4'd5, 4'd2},
    {32'h1A38_B192, 16'b00_01_00_00_10_00_00_00, 4'd3, 4'd2},
    {32'hB112_3189, 16'b10_00_00_00_00_00_00_01, 4'd0, 4'd1},
    {32'hB213_2811, 16'b00_00_00_00_00_10_00_00, 4'd7, 4'd2},
    {32'h8888_8888, 16'b01_10_01_10_01_10_01_10, 4'd8, 4'd8}
  };

  typedef struct {
    branch_pkg::issue_t    issue;
    logic                  has_redirect;
    branch_pkg::redirect_t redirect;
    time                   due;
  } expect_t;

  logic                  w_IssueFifoFire_1;
  logic                  rstn;
  logic                  i_pkt_valid;
  branch_pkg::packet_t   i_pkt;
  logic                  o_issue_valid;
  branch_pkg::issue_t    o_issue;
  logic                  o_redirect_valid;
  branch_pkg::redirect_t o_redirect;

  logic [31:0] rng_state;
  expect_t     exp_q[$];
  expect_t     head;

  branch_detect_top UUT (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_pkt_valid       (i_pkt_valid),
    .i_pkt             (i_pkt),
    .o_issue_valid     (o_issue_valid),
    .o_issue           (o_issue),
    .o_redirect_valid  (o_redirect_valid),
    .o_redirect        (o_redirect)
  );

  bind branch_detect_top branch_detect_properties u_props (
    .w_IssueFifoFire_1 (w_IssueFifoFire_1),
    .rstn              (rstn),
    .i_pkt_valid       (i_pkt_valid),
    .i_issue_valid     (o_issue_valid),
    .i_redirect_valid  (o_redirect_valid)
  );

  initial begin
    w_IssueFifoFire_1 = 1'b0;
    forever #(clk_period / 2) w_IssueFifoFire_1 = ~w_IssueFifoFire_1;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = next_random(rng_state);
    v = rng_state;
  endtask

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    stop_with_failure($sformatf("Mismatch at time %0t: %s", $time, what));
  endtask

  task automatic check_issue(input branch_pkg::issue_t got, input branch_pkg::issue_t exp);
    if (got.resolved_count !== exp.resolved_count) begin
      report_mismatch($sformatf("resolved_count got %0d expected %0d",
                                got.resolved_count, exp.resolved_count));
    end
    for (int s = 0; s < branch_pkg::slot_count; s++) begin
      if (got.packet[s] !== exp.packet[s]) begin
        report_mismatch($sformatf("issue slot %0d got %h expected %h",
                                  s, got.packet[s], exp.packet[s]));
      end
    end
  endtask

  task automatic check_redirect(input branch_pkg::redirect_t got,
                                input branch_pkg::redirect_t exp);
    if (got.target_pc !== exp.target_pc) begin
      report_mismatch($sformatf("target_pc got %h expected %h", got.target_pc, exp.target_pc));
    end
  endtask

  // random fields, with branch operands forced to the row's relation
  task automatic build_packet(input row_t row, output branch_pkg::packet_t pkt);
    logic [3:0]  kind;
    logic [1:0]  rel;
    logic [31:0] p;
    logic [31:0] a;
    logic [31:0] b;
    for (int s = 0; s < branch_pkg::slot_count; s++) begin
      kind = row.kinds[4*s +: 4];
      rel  = row.rels[2*s +: 2];
      draw(p);
      draw(a);
      draw(b);
      pkt[s] = '0;
      if (kind != 4'd0) begin
        pkt[s].pc        = {p[31:2], 2'b00};
        pkt[s].offset    = b[31:16];
        pkt[s].operand_l = a;
        pkt[s].operand_r = b;
        pkt[s].cond      = branch_pkg::cond_t'(b[1:0]);
        pkt[s].opcode    = branch_pkg::opcode_t'({1'b0, kind[1:0]});
      end
      if (kind[3]) begin
        pkt[s].opcode = branch_pkg::op_bjp;
        pkt[s].cond   = branch_pkg::cond_t'(kind[1:0]);
        // odd slots jump backwards
        pkt[s].offset[branch_pkg::offset_w-1] = ((s % 2) == 1);
        if (rel == 2'd0) begin
          pkt[s].operand_r = a;
        end else if (rel == 2'd1) begin
          pkt[s].operand_l = {1'b1, a[30:0]};
          pkt[s].operand_r = {1'b0, b[30:0]};
        end else begin
          pkt[s].operand_l = {1'b0, a[30:0]};
          pkt[s].operand_r = {1'b1, b[30:0]};
        end
      end
    end
  endtask

  function automatic expect_t predict(input branch_pkg::packet_t pkt, input row_t row);
    expect_t                       e;
    logic [2:0]                    k;
    logic [branch_pkg::data_w-1:0] ext;
    k                      = row.exp_idx[2:0];
    e.issue.packet         = pkt;
    e.issue.resolved_count = row.exp_count;
    e.has_redirect         = (row.exp_idx != 4'd8);
    e.redirect             = '0;
    e.due                  = 0;
    if (e.has_redirect) begin
      for (int s = 0; s < branch_pkg::slot_count; s++) begin
        if (s > int'(k)) begin
          e.issue.packet[s] = '0;
        end
      end
      ext = {{(branch_pkg::data_w-branch_pkg::offset_w){pkt[k].offset[branch_pkg::offset_w-1]}},
             pkt[k].offset};
      e.redirect.target_pc = pkt[k].pc + ext;
    end
    return e;
  endfunction

  task automatic send_row(input int idx);
    row_t                row;
    branch_pkg::packet_t pkt;
    expect_t             e;
    row = stim_table[idx];
    build_packet(row, pkt);
    e     = predict(pkt, row);
    e.due = $time + time'(4 * clk_period);
    exp_q.push_back(e);
    i_pkt_valid <= 1'b1;
    i_pkt       <= pkt;
  endtask

  // back to back, one packet per cycle
  task automatic run_table(input int rows);
    for (int i = 0; i < rows; i++) begin
      @(posedge w_IssueFifoFire_1);
      send_row(i);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > drain_limit) begin
        stop_with_failure("expected issue packet never came out");
      end
      @(posedge w_IssueFifoFire_1);
      waited++;
    end
  endtask

  always @(posedge w_IssueFifoFire_1) begin
    if (!rstn && (o_issue_valid || o_redirect_valid)) begin
      stop_with_failure("valid output high while reset is asserted");
    end
    if (o_redirect_valid && !o_issue_valid) begin
      stop_with_failure("redirect pulse came without an issue packet");
    end
    if (o_issue_valid) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("issue packet came out with none pending");
      end else begin
        head = exp_q.pop_front();
        if ($time != head.due) begin
          report_mismatch($sformatf("issue packet due at %0t", head.due));
        end
        check_issue(o_issue, head.issue);
        if (o_redirect_valid !== head.has_redirect) begin
          report_mismatch($sformatf("redirect valid got %b expected %b",
                                    o_redirect_valid, head.has_redirect));
        end
        if (head.has_redirect) begin
          check_redirect(o_redirect, head.redirect);
        end
      end
    end
  end

  initial begin
    rng_state   = 32'h8d88d1a1;
    rstn        = 1'b0;
    i_pkt_valid = 1'b0;
    i_pkt       = '0;
    repeat (2) @(posedge w_IssueFifoFire_1);
    rstn <= 1'b1;
    @(posedge w_IssueFifoFire_1);
    run_table(row_count);
    @(posedge w_IssueFifoFire_1);
    i_pkt_valid <= 1'b0;
    wait_drain();
    // reset with three packets still in the pipe
    run_table(3);
    @(posedge w_IssueFifoFire_1);
    i_pkt_valid <= 1'b0;
    rstn        <= 1'b0;
    @(posedge w_IssueFifoFire_1);
    exp_q.delete();
    @(posedge w_IssueFifoFire_1);
    rstn <= 1'b1;
    // any stale packet shows up here as unexpected
    repeat (6) @(posedge w_IssueFifoFire_1);
    run_table(row_count);
    @(posedge w_IssueFifoFire_1);
    i_pkt_valid <= 1'b0;
    wait_drain();
    if (exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure("packets left pending at the end");
    end
  end

endmodule

//--- build.f
branch_pkg.sv
branch_decode.sv
branch_execute.sv
branch_result.sv
branch_detect_top.sv
branch_detect_properties.sv
tb_branch_detect.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_branch_detect
FILELIST  = build.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(TOOL) and run it"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
